// File: verilog/cu_setup_pkg.sv
package cu_setup_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Byte address toward memory
    parameter int ADDRESS_W = 32;

    // Word counts and word indices
    parameter int COUNT_W = 16;

    // log2 of the bytes per memory word, 64 bytes
    parameter int WORD_SHIFT = 6;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    typedef logic [ADDRESS_W-1:0] address_t;

    typedef logic [COUNT_W-1:0] word_count_t;

    // Setup phases, program first and flush second
    typedef enum logic [2:0] {
        CU_SETUP_RESET,
        CU_SETUP_IDLE,
        CU_SETUP_PROGRAM_START,
        CU_SETUP_PROGRAM_BUSY,
        CU_SETUP_PROGRAM_DONE,
        CU_SETUP_FLUSH_START,
        CU_SETUP_FLUSH_BUSY,
        CU_SETUP_FLUSH_DONE
    } cu_setup_state_t;

endpackage : cu_setup_pkg

// File: verilog/cu_setup_config.sv
module cu_setup_config (
    input  logic                      ap_clk,
    input  logic                      areset_cu_setup,
    input  logic                      descriptor_req,
    output logic                      descriptor_ack,
    input  cu_setup_pkg::address_t    descriptor_base,
    input  cu_setup_pkg::word_count_t descriptor_program_size,
    input  cu_setup_pkg::word_count_t descriptor_flush_size,
    input  logic                      descriptor_flush_enable,
    output logic                      descriptor_valid,
    output cu_setup_pkg::address_t    base_address,
    output cu_setup_pkg::word_count_t program_size,
    output cu_setup_pkg::word_count_t flush_size,
    output logic                      flush_enable
);

    // Only the first descriptor after reset is taken
    logic take;

    assign take = descriptor_req && !descriptor_valid;

    // ----------------------------------------
    // Four-phase handshake
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            descriptor_ack   <= 1'b0;
            descriptor_valid <= 1'b0;
        end else if (take) begin
            descriptor_ack   <= 1'b1;
            descriptor_valid <= 1'b1;
        end else if (!descriptor_req) begin
            descriptor_ack <= 1'b0;
        end
    end

    // Descriptor fields captured with the ack
    always_ff @(posedge ap_clk) begin
        if (take) begin
            base_address <= descriptor_base;
            program_size <= descriptor_program_size;
            flush_size   <= descriptor_flush_size;
            flush_enable <= descriptor_flush_enable;
        end
    end

    // Host keeps requesting until the first descriptor is acked
    req_held_until_ack : assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        descriptor_req && !descriptor_ack && !descriptor_valid |=> descriptor_req);

endmodule : cu_setup_config

// File: verilog/cu_setup_control.sv
module cu_setup_control (
    input  logic                      ap_clk,
    input  logic                      areset_cu_setup,
    input  logic                      descriptor_valid,
    input  cu_setup_pkg::word_count_t program_size,
    input  cu_setup_pkg::word_count_t flush_size,
    input  logic                      flush_enable,
    input  logic                      cu_flush,
    input  logic                      engine_idle,
    input  logic                      fifo_empty,
    input  logic                      response_valid,
    output logic                      engine_start,
    output logic                      phase_flush,
    output cu_setup_pkg::word_count_t phase_size,
    output logic                      done
);

    cu_setup_pkg::cu_setup_state_t state;
    cu_setup_pkg::cu_setup_state_t next_state;

    // Responses still owed for the running phase
    cu_setup_pkg::word_count_t response_count;

    logic cu_flush_reg;
    logic phase_end;

    // Nothing in flight anywhere
    assign phase_end = engine_idle && fifo_empty && (response_count == '0);

    assign engine_start = (state == cu_setup_pkg::CU_SETUP_PROGRAM_START) ||
                          (state == cu_setup_pkg::CU_SETUP_FLUSH_START);

    assign phase_flush = (state == cu_setup_pkg::CU_SETUP_FLUSH_START) ||
                         (state == cu_setup_pkg::CU_SETUP_FLUSH_BUSY) ||
                         (state == cu_setup_pkg::CU_SETUP_FLUSH_DONE);

    assign phase_size = phase_flush ? flush_size : program_size;

    // ----------------------------------------
    // Phase FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state <= cu_setup_pkg::CU_SETUP_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cu_setup_pkg::CU_SETUP_RESET: begin
                next_state = cu_setup_pkg::CU_SETUP_IDLE;
            end
            cu_setup_pkg::CU_SETUP_IDLE: begin
                if (descriptor_valid) begin
                    next_state = cu_setup_pkg::CU_SETUP_PROGRAM_START;
                end
            end
            cu_setup_pkg::CU_SETUP_PROGRAM_START: begin
                next_state = cu_setup_pkg::CU_SETUP_PROGRAM_BUSY;
            end
            cu_setup_pkg::CU_SETUP_PROGRAM_BUSY: begin
                if (phase_end) begin
                    next_state = cu_setup_pkg::CU_SETUP_PROGRAM_DONE;
                end
            end
            cu_setup_pkg::CU_SETUP_PROGRAM_DONE: begin
                // Park here until the host asks for the flush
                if (!flush_enable) begin
                    next_state = cu_setup_pkg::CU_SETUP_FLUSH_DONE;
                end else if (cu_flush_reg) begin
                    next_state = cu_setup_pkg::CU_SETUP_FLUSH_START;
                end
            end
            cu_setup_pkg::CU_SETUP_FLUSH_START: begin
                next_state = cu_setup_pkg::CU_SETUP_FLUSH_BUSY;
            end
            cu_setup_pkg::CU_SETUP_FLUSH_BUSY: begin
                if (phase_end) begin
                    next_state = cu_setup_pkg::CU_SETUP_FLUSH_DONE;
                end
            end
            cu_setup_pkg::CU_SETUP_FLUSH_DONE: begin
                next_state = cu_setup_pkg::CU_SETUP_FLUSH_DONE;
            end
            default: begin
                next_state = cu_setup_pkg::CU_SETUP_RESET;
            end
        endcase
    end

    // ----------------------------------------
    // Response counter and done
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            response_count <= '0;
            cu_flush_reg   <= 1'b0;
            done           <= 1'b0;
        end else begin
            cu_flush_reg <= cu_flush;
            done         <= (state == cu_setup_pkg::CU_SETUP_FLUSH_DONE);
            if (engine_start) begin
                response_count <= phase_size;
            end else if (response_valid && (response_count != '0)) begin
                response_count <= response_count - 1'b1;
            end
        end
    end

    // More responses than requests issued
    counter_no_underflow : assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        response_valid |-> (response_count != '0));

    no_response_in_idle : assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        response_valid |-> (state != cu_setup_pkg::CU_SETUP_IDLE));

endmodule : cu_setup_control

// File: verilog/cu_setup_read_engine.sv
module cu_setup_read_engine (
    input  logic                      ap_clk,
    input  logic                      areset_cu_setup,
    input  logic                      engine_start,
    input  logic                      phase_flush,
    input  cu_setup_pkg::word_count_t phase_size,
    input  cu_setup_pkg::address_t    base_address,
    input  logic                      fifo_prog_full,
    output logic                      engine_idle,
    output logic                      push,
    output cu_setup_pkg::address_t    push_address,
    output logic                      push_flush
);

    logic                      busy;
    cu_setup_pkg::word_count_t word_index;
    cu_setup_pkg::word_count_t next_index;
    logic                      all_issued;
    logic                      last_push;

    assign next_index = word_index + 1'b1;
    assign all_issued = (word_index == phase_size);
    assign last_push  = push && (next_index == phase_size);

    // ----------------------------------------
    // Request generation
    // ----------------------------------------

    // Hold off while the FIFO is above its threshold
    assign push = busy && !all_issued && !fifo_prog_full;

    // Word index scaled to a byte offset
    assign push_address = base_address +
                          (cu_setup_pkg::address_t'(word_index) << cu_setup_pkg::WORD_SHIFT);

    assign push_flush  = phase_flush;
    assign engine_idle = !busy;

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            busy       <= 1'b0;
            word_index <= '0;
        end else if (engine_start) begin
            busy       <= 1'b1;
            word_index <= '0;
        end else if (busy) begin
            if (push) begin
                word_index <= next_index;
            end
            // Zero-size phase drops out right away
            if (last_push || all_issued) begin
                busy <= 1'b0;
            end
        end
    end

endmodule : cu_setup_read_engine

// File: verilog/cu_setup_request_fifo.sv
module cu_setup_request_fifo #(
    parameter int FIFO_DEPTH  = 32,
    parameter int PROG_THRESH = 16
) (
    input  logic                   ap_clk,
    input  logic                   areset_cu_setup,
    input  logic                   push,
    input  cu_setup_pkg::address_t push_address,
    input  logic                   push_flush,
    output logic                   fifo_prog_full,
    output logic                   fifo_empty,
    output logic                   request_valid,
    input  logic                   request_ready,
    output cu_setup_pkg::address_t request_address,
    output logic                   request_flush
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] DEPTH_COUNT  = (PTR_W + 1)'(FIFO_DEPTH);
    localparam logic [PTR_W:0] THRESH_COUNT = (PTR_W + 1)'(PROG_THRESH);

    cu_setup_pkg::address_t address_mem [FIFO_DEPTH];
    logic                   flush_mem   [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             fifo_full;
    logic             pop;

    assign fifo_empty     = (count == '0);
    assign fifo_full      = (count == DEPTH_COUNT);
    assign fifo_prog_full = (count >= THRESH_COUNT);

    // Head entry is shown before it is taken
    assign request_valid   = !fifo_empty;
    assign request_address = address_mem[rd_ptr];
    assign request_flush   = flush_mem[rd_ptr];
    assign pop             = request_valid && request_ready;

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            address_mem[wr_ptr] <= push_address;
            flush_mem[wr_ptr]   <= push_flush;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Engine back-pressure keeps the FIFO below full
    no_push_when_full : assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        push |-> !fifo_full);

endmodule : cu_setup_request_fifo

// File: verilog/cu_setup.sv
module cu_setup #(
    parameter int FIFO_DEPTH  = 32,
    parameter int PROG_THRESH = 16
) (
    input  logic                      ap_clk,
    input  logic                      areset_cu_setup,
    input  logic                      descriptor_req,
    output logic                      descriptor_ack,
    input  cu_setup_pkg::address_t    descriptor_base,
    input  cu_setup_pkg::word_count_t descriptor_program_size,
    input  cu_setup_pkg::word_count_t descriptor_flush_size,
    input  logic                      descriptor_flush_enable,
    input  logic                      cu_flush,
    output logic                      request_valid,
    input  logic                      request_ready,
    output cu_setup_pkg::address_t    request_address,
    output logic                      request_flush,
    input  logic                      response_valid,
    output logic                      done
);

    // ----------------------------------------
    // Internal wires
    // ----------------------------------------
    logic                      descriptor_valid;
    cu_setup_pkg::address_t    base_address;
    cu_setup_pkg::word_count_t program_size;
    cu_setup_pkg::word_count_t flush_size;
    logic                      flush_enable;

    logic                      engine_start;
    logic                      phase_flush;
    cu_setup_pkg::word_count_t phase_size;
    logic                      engine_idle;

    logic                      push;
    cu_setup_pkg::address_t    push_address;
    logic                      push_flush;
    logic                      fifo_prog_full;
    logic                      fifo_empty;

    // Descriptor capture
    cu_setup_config cu_setup_config_i (
        .ap_clk                  (ap_clk),
        .areset_cu_setup         (areset_cu_setup),
        .descriptor_req          (descriptor_req),
        .descriptor_ack          (descriptor_ack),
        .descriptor_base         (descriptor_base),
        .descriptor_program_size (descriptor_program_size),
        .descriptor_flush_size   (descriptor_flush_size),
        .descriptor_flush_enable (descriptor_flush_enable),
        .descriptor_valid        (descriptor_valid),
        .base_address            (base_address),
        .program_size            (program_size),
        .flush_size              (flush_size),
        .flush_enable            (flush_enable)
    );

    // Phase sequencing
    cu_setup_control cu_setup_control_i (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_valid (descriptor_valid),
        .program_size     (program_size),
        .flush_size       (flush_size),
        .flush_enable     (flush_enable),
        .cu_flush         (cu_flush),
        .engine_idle      (engine_idle),
        .fifo_empty       (fifo_empty),
        .response_valid   (response_valid),
        .engine_start     (engine_start),
        .phase_flush      (phase_flush),
        .phase_size       (phase_size),
        .done             (done)
    );

    cu_setup_read_engine cu_setup_read_engine_i (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .engine_start    (engine_start),
        .phase_flush     (phase_flush),
        .phase_size      (phase_size),
        .base_address    (base_address),
        .fifo_prog_full  (fifo_prog_full),
        .engine_idle     (engine_idle),
        .push            (push),
        .push_address    (push_address),
        .push_flush      (push_flush)
    );

    cu_setup_request_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) cu_setup_request_fifo_i (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push            (push),
        .push_address    (push_address),
        .push_flush      (push_flush),
        .fifo_prog_full  (fifo_prog_full),
        .fifo_empty      (fifo_empty),
        .request_valid   (request_valid),
        .request_ready   (request_ready),
        .request_address (request_address),
        .request_flush   (request_flush)
    );

endmodule : cu_setup

// File: testbench/cu_setup_tb.sv
module cu_setup_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT      = 2000;
    localparam int READY_HIGH   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;

    logic                      ap_clk = 1'b0;
    logic                      areset_cu_setup = 1'b1;
    logic                      descriptor_req = 1'b0;
    logic                      descriptor_ack;
    cu_setup_pkg::address_t    descriptor_base = '0;
    cu_setup_pkg::word_count_t descriptor_program_size = '0;
    cu_setup_pkg::word_count_t descriptor_flush_size = '0;
    logic                      descriptor_flush_enable = 1'b0;
    logic                      cu_flush = 1'b0;
    logic                      request_valid;
    logic                      request_ready = 1'b0;
    cu_setup_pkg::address_t    request_address;
    logic                      request_flush;
    logic                      response_valid = 1'b0;
    logic                      done;

    int          ready_mode = READY_HIGH;
    logic        hold_responses = 1'b0;
    logic [31:0] lfsr = 32'h86bffc7a;
    int          error_count = 0;
    int          responses_sent = 0;

    // Accepted requests in order, and the delays of owed responses
    cu_setup_pkg::address_t captured_address[$];
    logic                   captured_flush[$];
    int                     response_delay[$];

    cu_setup cu_setup_i (.*);

    initial begin
        forever begin
            #2 ap_clk = ~ap_clk;
        end
    end

    // Taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic take_bit();
        logic feedback;
        feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], feedback};
        return feedback;
    endfunction

    // ----------------------------------------
    // Request capture and response model
    // ----------------------------------------
    always @(posedge ap_clk) begin
        logic [1:0] delay;
        if (areset_cu_setup) begin
            captured_address.delete();
            captured_flush.delete();
            response_delay.delete();
            responses_sent = 0;
            response_valid <= 1'b0;
            request_ready  <= 1'b0;
        end else begin
            if (request_valid && request_ready) begin
                captured_address.push_back(request_address);
                captured_flush.push_back(request_flush);
                delay[0] = take_bit();
                delay[1] = take_bit();
                response_delay.push_back(int'(delay));
            end
            response_valid <= 1'b0;
            if (!hold_responses && response_delay.size() > 0) begin
                if (response_delay[0] == 0) begin
                    void'(response_delay.pop_front());
                    response_valid <= 1'b1;
                    responses_sent++;
                end else begin
                    response_delay[0] = response_delay[0] - 1;
                end
            end
            case (ready_mode)
                READY_HIGH:   request_ready <= 1'b1;
                READY_RANDOM: request_ready <= take_bit();
                default:      request_ready <= 1'b0;
            endcase
        end
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic compare_address(input string name, input cu_setup_pkg::address_t actual,
                                   input cu_setup_pkg::address_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("error: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_flush(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            error_count++;
            $display("error: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_count(input string name, input cu_setup_pkg::word_count_t actual,
                                 input cu_setup_pkg::word_count_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("error: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic report(input string text);
        error_count++;
        $display("%s", text);
    endtask

    // ----------------------------------------
    // Waits and helpers
    // ----------------------------------------
    task automatic wait_ack(input logic level, output logic seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge ap_clk);
            seen = (descriptor_ack == level);
            cycles++;
        end
    endtask

    task automatic wait_done();
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge ap_clk);
            seen = done;
            cycles++;
        end
        if (!seen) begin
            report("Timed out waiting for done");
        end
    endtask

    // Queue is written at the rising edge, so poll on the falling one
    task automatic wait_request_count(input int count);
        int cycles;
        cycles = 0;
        while (captured_address.size() < count && cycles < TIMEOUT) begin
            @(negedge ap_clk);
            cycles++;
        end
        if (captured_address.size() < count) begin
            report("Timed out waiting for requests");
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge ap_clk);
            if (done) begin
                report("done rose while work was still pending");
            end
        end
    endtask

    task automatic reset_dut();
        @(posedge ap_clk);
        areset_cu_setup <= 1'b1;
        descriptor_req  <= 1'b0;
        cu_flush        <= 1'b0;
        ready_mode      <= READY_HIGH;
        hold_responses  <= 1'b0;
        repeat (4) @(posedge ap_clk);
        areset_cu_setup <= 1'b0;
    endtask

    task automatic send_descriptor(input cu_setup_pkg::address_t base,
                                   input cu_setup_pkg::word_count_t program_size,
                                   input cu_setup_pkg::word_count_t flush_size,
                                   input logic flush_enable);
        logic seen;
        @(posedge ap_clk);
        if (descriptor_ack) begin
            report("descriptor_ack high before descriptor_req");
        end
        descriptor_base         <= base;
        descriptor_program_size <= program_size;
        descriptor_flush_size   <= flush_size;
        descriptor_flush_enable <= flush_enable;
        descriptor_req          <= 1'b1;
        wait_ack(1'b1, seen);
        if (!seen) begin
            report("descriptor_ack did not rise after descriptor_req");
        end
        descriptor_req <= 1'b0;
        wait_ack(1'b0, seen);
        if (!seen) begin
            report("descriptor_ack did not fall after descriptor_req dropped");
        end
    endtask

    // Word i of a phase sits at base + i * 64
    task automatic check_requests(input int first, input int count,
                                  input cu_setup_pkg::address_t base, input logic flush);
        cu_setup_pkg::address_t expected;
        @(negedge ap_clk);
        expected = base;
        if (captured_address.size() < first + count) begin
            report("Fewer requests captured than expected");
        end else begin
            for (int i = 0; i < count; i++) begin
                compare_address("request_address", captured_address[first + i], expected);
                compare_flush("request_flush", captured_flush[first + i], flush);
                expected = expected + (cu_setup_pkg::address_t'(1) << cu_setup_pkg::WORD_SHIFT);
            end
        end
    endtask

    task automatic check_total(input int expected);
        @(negedge ap_clk);
        compare_count("request count", cu_setup_pkg::word_count_t'(captured_address.size()),
                      cu_setup_pkg::word_count_t'(expected));
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_program_only();
        reset_dut();
        send_descriptor(32'h1000_0000, 16'd10, 16'd0, 1'b0);
        wait_done();
        @(negedge ap_clk);
        compare_count("responses", cu_setup_pkg::word_count_t'(responses_sent), 16'd10);
        repeat (20) @(posedge ap_clk);
        check_total(10);
        check_requests(0, 10, 32'h1000_0000, 1'b0);
    endtask

    task automatic test_flush_phase();
        reset_dut();
        send_descriptor(32'h2000_0400, 16'd5, 16'd7, 1'b1);
        wait_request_count(5);
        expect_quiet(60);
        check_total(5);
        @(posedge ap_clk);
        cu_flush <= 1'b1;
        wait_done();
        check_total(12);
        check_requests(0, 5, 32'h2000_0400, 1'b0);
        check_requests(5, 7, 32'h2000_0400, 1'b1);
    endtask

    task automatic test_back_pressure();
        reset_dut();
        ready_mode <= READY_RANDOM;
        send_descriptor(32'h3000_0000, 16'd60, 16'd0, 1'b0);
        wait_request_count(10);
        @(posedge ap_clk);
        ready_mode <= READY_LOW;
        repeat (50) @(posedge ap_clk);
        ready_mode <= READY_RANDOM;
        wait_done();
        check_total(60);
        check_requests(0, 60, 32'h3000_0000, 1'b0);
    endtask

    task automatic test_done_waits();
        reset_dut();
        hold_responses <= 1'b1;
        send_descriptor(32'h4000_0000, 16'd4, 16'd0, 1'b0);
        wait_request_count(4);
        expect_quiet(50);
        @(posedge ap_clk);
        hold_responses <= 1'b0;
        wait_done();
        check_requests(0, 4, 32'h4000_0000, 1'b0);
    endtask

    task automatic test_handshake_zero();
        logic seen;
        reset_dut();
        send_descriptor(32'h5000_0000, 16'd0, 16'd0, 1'b0);
        wait_done();
        check_total(0);
        // Only one descriptor per reset
        @(posedge ap_clk);
        descriptor_req <= 1'b1;
        wait_ack(1'b1, seen);
        if (seen) begin
            report("Second descriptor was acknowledged before reset");
        end
        descriptor_req <= 1'b0;
    endtask

    initial begin
        test_program_only();
        test_flush_phase();
        test_back_pressure();
        test_done_waits();
        test_handshake_zero();
        @(negedge ap_clk);
        $display("cu_setup_tb: %0d errors", error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : cu_setup_tb

// File: cu_setup.f
verilog/cu_setup_pkg.sv
verilog/cu_setup_config.sv
verilog/cu_setup_control.sv
verilog/cu_setup_read_engine.sv
verilog/cu_setup_request_fifo.sv
verilog/cu_setup.sv
testbench/cu_setup_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module cu_setup_tb -f cu_setup.f -o cu_setup_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cu_setup_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
